//--- apb_mem_port.sv
/*
 * APB slave for the DRAM write port
 * Holds the address register, turns data writes into FIFO pushes,
 * stalls the host while the FIFO is full and reports status
 */
module apb_mem_port (
  input  logic                                 clk,
  input  logic                                 reset,
  // APB
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [mem_addr_pkg::paddr_w-1:0]     paddr,
  input  logic [mem_addr_pkg::pdata_w-1:0]     pwdata,
  output logic [mem_addr_pkg::pdata_w-1:0]     prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  // FIFO and controller feedback
  input  logic                                 full,
  input  logic [mem_addr_pkg::level_w-1:0]     level,
  input  logic                                 cycle_done,
  input  logic                                 busy,
  // FIFO write side
  output logic                                 push,
  output logic [mem_addr_pkg::addr_w-1:0]      push_addr,
  output logic [mem_addr_pkg::data_w-1:0]      push_data
);

  logic access;      // Access phase of a transfer
  logic off_addr;
  logic off_data;
  logic off_status;
  logic bad_off;     // Offset outside the register map
  logic addr_wr;
  logic data_wr;

  mem_addr_pkg::mem_addr_u          addr_q;    // Address for the next data write
  logic [mem_addr_pkg::cnt_w-1:0]   done_cnt;  // Completed DRAM cycles

  // Decode
  assign access     = psel & penable;
  assign off_addr   = (paddr == mem_addr_pkg::reg_addr_off);
  assign off_data   = (paddr == mem_addr_pkg::reg_data_off);
  assign off_status = (paddr == mem_addr_pkg::reg_status_off);
  assign bad_off    = ~(off_addr | off_data | off_status);

  assign addr_wr = access & pwrite & off_addr;
  assign data_wr = access & pwrite & off_data;

  // Error response, no state is touched on a bad offset
  assign pslverr = access & bad_off;

  // Wait states only while a data write meets a full FIFO
  assign pready = ~(data_wr & full);

  // Request goes out in the access cycle that finds a free slot
  assign push      = data_wr & ~full;
  assign push_addr = addr_q.flat;
  assign push_data = pwdata[mem_addr_pkg::data_w-1:0];

  // Host loads the word address before each data write
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_q.flat <= '0;
    end else if (addr_wr) begin
      addr_q.flat <= pwdata[mem_addr_pkg::addr_w-1:0];
    end
  end

  // One count per finished write cycle, wraps at 16 bits
  always_ff @(posedge clk) begin
    if (reset) begin
      done_cnt <= '0;
    end else if (cycle_done) begin
      done_cnt <= done_cnt + 1'b1;
    end
  end

  // Read data
  always_comb begin
    prdata = '0;  // Data register and bad offsets read zero
    if (off_addr) begin
      prdata[mem_addr_pkg::addr_w-1:0] = addr_q.flat;
    end else if (off_status) begin
      prdata = {done_cnt, {mem_addr_pkg::status_pad{1'b0}}, level, busy};
    end
  end

endmodule

//--- dram_cycle_ctrl.sv
/*
 * DRAM write cycle controller
 * Pops one request at a time and runs LATCH, RAS, CAS and PRE,
 * driving the strobes and steering the address mux
 */
module dram_cycle_ctrl (
  input  logic                              clk,
  input  logic                              reset,
  // FIFO read side
  input  logic                              empty,
  input  logic [mem_addr_pkg::addr_w-1:0]   pop_addr,
  input  logic [mem_addr_pkg::data_w-1:0]   pop_data,
  output logic                              pop,
  // Power down straight to the mux
  input  logic                              pd4,
  // DRAM pins
  output logic [mem_addr_pkg::half_w-1:0]   aa,
  output logic                              ras_n,
  output logic                              cas_n,
  output logic                              we_n,
  output logic [mem_addr_pkg::data_w-1:0]   dq_out,
  // Status back to the port
  output logic                              cycle_done,
  output logic                              busy
);

  logic [mem_addr_pkg::st_w-1:0]   state;
  logic [mem_addr_pkg::st_w-1:0]   state_nxt;
  logic [mem_addr_pkg::data_w-1:0] data_q;  // Write data held for CAS

  logic in_latch;
  logic in_ras;
  logic in_cas;
  logic in_pre;
  logic bcgnt50;
  logic loen_n;
  logic hien_n;

  assign in_latch = (state == mem_addr_pkg::st_latch);
  assign in_ras   = (state == mem_addr_pkg::st_ras);
  assign in_cas   = (state == mem_addr_pkg::st_cas);
  assign in_pre   = (state == mem_addr_pkg::st_pre);

  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      mem_addr_pkg::st_idle:  if (!empty) state_nxt = mem_addr_pkg::st_latch;
      mem_addr_pkg::st_latch: state_nxt = mem_addr_pkg::st_ras;
      mem_addr_pkg::st_ras:   state_nxt = mem_addr_pkg::st_cas;
      mem_addr_pkg::st_cas:   state_nxt = mem_addr_pkg::st_pre;
      mem_addr_pkg::st_pre: begin
        // Back to back cycles when more work is queued
        state_nxt = empty ? mem_addr_pkg::st_idle : mem_addr_pkg::st_latch;
      end
      default: state_nxt = mem_addr_pkg::st_idle;  // Unused codes recover
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mem_addr_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // Data taken with the pop, head is valid in LATCH
  always_ff @(posedge clk) begin
    if (in_latch) begin
      data_q <= pop_data;
    end
  end

  // Head leaves the FIFO at the end of LATCH
  assign pop     = in_latch;
  assign bcgnt50 = in_latch;  // Mux grabs both halves on the same edge

  // Mux steering, row during RAS and column during CAS
  assign loen_n = ~in_ras;
  assign hien_n = ~in_cas;

  // Strobes, RAS held low through CAS
  assign ras_n = ~(in_ras | in_cas);
  assign cas_n = ~in_cas;
  assign we_n  = ~in_cas;  // Every cycle is a write

  assign dq_out = in_cas ? data_q : '0;  // Driven only while CAS is low

  assign cycle_done = in_pre;
  assign busy       = (state != mem_addr_pkg::st_idle);

  mem_addr_mux u_mux (
    .clk     (clk),
    .reset   (reset),
    .bcgnt50 (bcgnt50),
    .loen_n  (loen_n),
    .hien_n  (hien_n),
    .pd4     (pd4),
    .lbd     (pop_addr),
    .aa      (aa)
  );

endmodule

//--- flist.f
mem_addr_pkg.sv
apb_mem_port.sv
mem_req_fifo.sv
mem_addr_mux.sv
dram_cycle_ctrl.sv
mem_addr_top.sv
mem_addr_checker.sv
tb_mem_addr.sv

//--- mem_addr_checker.sv
/*
 * Checker for the DRAM address path testbench
 * Follows the strobes and the APB responses on the falling clock edge
 * and compares them with the vector table of the testbench top
 */
module mem_addr_checker (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [mem_addr_pkg::paddr_w-1:0]  paddr,
  input  logic [mem_addr_pkg::pdata_w-1:0]  pwdata,
  input  logic [mem_addr_pkg::pdata_w-1:0]  prdata,
  input  logic                              pready,
  input  logic                              pslverr,
  input  logic [mem_addr_pkg::half_w-1:0]   aa,
  input  logic                              ras_n,
  input  logic                              cas_n,
  input  logic                              we_n,
  input  logic [mem_addr_pkg::data_w-1:0]   dq_out,
  input  logic                              final_rd  // Closing status read in progress
);

  int                              errors = 0;
  int                              ras_cnt = 0;      // Row strobes seen
  logic [5:0]                      idx = '0;         // Request now on the pins
  logic                            stall_seen = 1'b0;
  logic                            final_seen = 1'b0;
  logic                            ras_q = 1'b1;     // Strobes one clock back
  logic                            cas_q = 1'b1;
  logic [mem_addr_pkg::addr_w-1:0] host_addr = '0;   // Address register as the host left it

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("MISMATCH %0t: %s", $time, msg);
  endtask

  task automatic raise_fault(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // Pins are settled half a clock after the edge that moved them
  always @(negedge clk) begin
    logic [mem_addr_pkg::addr_w-1:0]  exp_addr;
    logic [mem_addr_pkg::half_w-1:0]  exp_row;
    logic [mem_addr_pkg::half_w-1:0]  exp_col;
    logic [mem_addr_pkg::pdata_w-1:0] exp_status;
    logic                             bad_off;
    exp_addr = tb_mem_addr.vec_addr[idx];
    exp_row  = tb_mem_addr.vec_pd[idx] ? '0 : exp_addr[mem_addr_pkg::half_w-1:0];  // Buffer off
    exp_col  = tb_mem_addr.vec_pd[idx] ? '0 : exp_addr[mem_addr_pkg::addr_w-1:mem_addr_pkg::half_w];
    if (!reset) begin
      if (!pready) stall_seen = 1'b1;
      if (ras_q && !ras_n) begin
        ras_cnt++;
        if (int'(idx) >= tb_mem_addr.n_vec) raise_fault("row strobe with no request left");
        else if (aa !== exp_row) flag_mismatch($sformatf("row aa=%h expected %h", aa, exp_row));
      end
      if (cas_q && !cas_n) begin
        if (ras_n) raise_fault("column strobe while ras_n is high");
        else if (aa !== exp_col) flag_mismatch($sformatf("col aa=%h expected %h", aa, exp_col));
      end
      if (!cas_n) begin
        if (we_n !== 1'b0) flag_mismatch("we_n high during column strobe");
        if (dq_out !== tb_mem_addr.vec_data[idx]) begin
          flag_mismatch($sformatf("dq_out=%h expected %h", dq_out, tb_mem_addr.vec_data[idx]));
        end
      end
      if (!cas_q && cas_n) idx++;  // Request retired as CAS rises
      ras_q = ras_n;
      cas_q = cas_n;
      // APB transfer completing on the next rising edge
      if (psel && penable && pready) begin
        bad_off = !(paddr == mem_addr_pkg::reg_addr_off || paddr == mem_addr_pkg::reg_data_off ||
                    paddr == mem_addr_pkg::reg_status_off);
        if (pslverr !== bad_off) begin
          flag_mismatch($sformatf("pslverr=%b at offset %h", pslverr, paddr));
        end
        if (pwrite && paddr == mem_addr_pkg::reg_addr_off) host_addr = pwdata[19:0];
        if (!pwrite && paddr == mem_addr_pkg::reg_addr_off && prdata !== {12'h0, host_addr}) begin
          flag_mismatch($sformatf("address register %h expected %h", prdata, host_addr));
        end
        if (!pwrite && paddr == mem_addr_pkg::reg_status_off && final_rd) begin
          final_seen = 1'b1;
          exp_status = {16'(tb_mem_addr.n_vec), 16'h0000};  // Idle and FIFO drained
          if (prdata !== exp_status) begin
            flag_mismatch($sformatf("status %h expected %h", prdata, exp_status));
          end
          if (int'(idx) != tb_mem_addr.n_vec || ras_cnt != tb_mem_addr.n_vec) begin
            raise_fault($sformatf("%0d row strobes and %0d retired requests for %0d vectors",
                                  ras_cnt, idx, tb_mem_addr.n_vec));
          end
          if (!stall_seen) raise_fault("pready never went low, the FIFO never filled");
        end
      end
    end
  end

endmodule

//--- mem_addr_mux.sv
/*
 * DRAM address multiplexer
 * Captures row and column halves of the local bus address on bcgnt50
 * and puts one of them on aa, forced to zero in power-down
 */
module mem_addr_mux (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              bcgnt50,  // Latch strobe for both halves
  input  logic                              loen_n,   // Row half onto aa
  input  logic                              hien_n,   // Column half onto aa
  input  logic                              pd4,      // Power down
  input  mem_addr_pkg::mem_addr_u           lbd,      // Local bus address
  output logic [mem_addr_pkg::half_w-1:0]   aa        // Multiplexed DRAM address
);

  logic [mem_addr_pkg::half_w-1:0] row_q;    // Low half latch
  logic [mem_addr_pkg::half_w-1:0] col_q;    // High half latch
  logic [mem_addr_pkg::half_w-1:0] row_out;
  logic [mem_addr_pkg::half_w-1:0] col_out;
  logic [mem_addr_pkg::half_w-1:0] bus;      // Shared bus behind the output buffer

  // Both halves taken in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      row_q <= '0;
      col_q <= '0;
    end else if (bcgnt50) begin
      row_q <= lbd.rc.row;
      col_q <= lbd.rc.col;
    end
  end

  // Disabled latch leaves the bus at zero
  assign row_out = loen_n ? '0 : row_q;
  assign col_out = hien_n ? '0 : col_q;

  // Wired together, only one enable is low at a time
  assign bus = row_out | col_out;

  // Output buffer shut off in power-down
  assign aa = pd4 ? '0 : bus;

endmodule

//--- mem_addr_pkg.sv
/*
 * Memory address path package
 * Bus widths, FIFO sizing, APB register map, cycle controller state
 * codes and the row/column view of the local bus address
 */
package mem_addr_pkg;

  // Local bus and DRAM widths
  localparam int addr_w = 20;  // Word address on the local bus
  localparam int half_w = 10;  // One multiplexed half, also width of aa
  localparam int data_w = 16;  // Write data

  // APB side
  localparam int paddr_w = 4;   // Byte offset into the register block
  localparam int pdata_w = 32;  // APB data bus

  // Request FIFO
  localparam int fifo_depth = 4;
  localparam int ptr_w      = 2;  // Index into fifo_depth entries
  localparam int level_w    = 3;  // Counts 0 to fifo_depth

  // Register offsets
  localparam logic [paddr_w-1:0] reg_addr_off   = 4'h0;  // Address, read/write
  localparam logic [paddr_w-1:0] reg_data_off   = 4'h4;  // Data, write pushes a request
  localparam logic [paddr_w-1:0] reg_status_off = 4'h8;  // Status, read only

  // Status word layout
  localparam int cnt_w      = 16;  // Completed cycle counter in bits 31:16
  localparam int status_pad = pdata_w - cnt_w - level_w - 1;

  // Cycle controller states
  localparam int st_w = 3;
  localparam logic [st_w-1:0] st_idle  = 3'd0;  // Waiting for a request
  localparam logic [st_w-1:0] st_latch = 3'd1;  // Pop and capture both halves
  localparam logic [st_w-1:0] st_ras   = 3'd2;  // Row strobe
  localparam logic [st_w-1:0] st_cas   = 3'd3;  // Column strobe and write
  localparam logic [st_w-1:0] st_pre   = 3'd4;  // Precharge, cycle ends

  // Row sits in the low half, column in the high half
  typedef struct packed {
    logic [half_w-1:0] col;
    logic [half_w-1:0] row;
  } mem_addr_rc_s;

  // Same 20 bits seen flat by the APB port and split by the mux
  typedef union packed {
    logic [addr_w-1:0] flat;
    mem_addr_rc_s      rc;
  } mem_addr_u;

endpackage

//--- mem_addr_top.sv
/*
 * DRAM address path top level
 * APB port feeding the request FIFO, drained by the cycle controller
 */
module mem_addr_top (
  input  logic                              clk,
  input  logic                              reset,
  // APB
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [mem_addr_pkg::paddr_w-1:0]  paddr,
  input  logic [mem_addr_pkg::pdata_w-1:0]  pwdata,
  output logic [mem_addr_pkg::pdata_w-1:0]  prdata,
  output logic                              pready,
  output logic                              pslverr,
  // Power down
  input  logic                              pd4,
  // DRAM pins
  output logic [mem_addr_pkg::half_w-1:0]   aa,
  output logic                              ras_n,
  output logic                              cas_n,
  output logic                              we_n,
  output logic [mem_addr_pkg::data_w-1:0]   dq_out
);

  logic                             push;
  logic [mem_addr_pkg::addr_w-1:0]  push_addr;
  logic [mem_addr_pkg::data_w-1:0]  push_data;
  logic                             pop;
  logic [mem_addr_pkg::addr_w-1:0]  pop_addr;
  logic [mem_addr_pkg::data_w-1:0]  pop_data;
  logic                             empty;
  logic                             full;
  logic [mem_addr_pkg::level_w-1:0] level;
  logic                             cycle_done;
  logic                             busy;

  apb_mem_port u_port (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .full       (full),
    .level      (level),
    .cycle_done (cycle_done),
    .busy       (busy),
    .push       (push),
    .push_addr  (push_addr),
    .push_data  (push_data)
  );

  mem_req_fifo u_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_addr (push_addr),
    .push_data (push_data),
    .pop       (pop),
    .pop_addr  (pop_addr),
    .pop_data  (pop_data),
    .empty     (empty),
    .full      (full),
    .level     (level)
  );

  dram_cycle_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .empty      (empty),
    .pop_addr   (pop_addr),
    .pop_data   (pop_data),
    .pop        (pop),
    .pd4        (pd4),
    .aa         (aa),
    .ras_n      (ras_n),
    .cas_n      (cas_n),
    .we_n       (we_n),
    .dq_out     (dq_out),
    .cycle_done (cycle_done),
    .busy       (busy)
  );

endmodule

//--- mem_addr_vectors.txt
# addr (20-bit hex, col in 19:10, row in 9:0)  data (16-bit hex)  pd4 (0 or 1)
# Lines that repeat the address of the line before go out back to back
3A5C7 1234 0
0F0F0 BEEF 1
FFFFF 0001 0
12345 A5A5 1
80001 5A5A 0
003FF C3C3 0
2B6D9 0101 0
2B6D9 0202 0
2B6D9 0303 0
2B6D9 0404 0
2B6D9 0505 0
2B6D9 0606 0
2B6D9 0707 0
2B6D9 0808 0
2B6D9 0909 0
2B6D9 0A0A 0
2B6D9 0B0B 0
2B6D9 0C0C 0

//--- mem_req_fifo.sv
/*
 * Request FIFO
 * Circular buffer of pending address/data pairs between the APB port
 * and the cycle controller, push and pop allowed in one cycle
 */
module mem_req_fifo (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              push,
  input  logic [mem_addr_pkg::addr_w-1:0]   push_addr,
  input  logic [mem_addr_pkg::data_w-1:0]   push_data,
  input  logic                              pop,
  output logic [mem_addr_pkg::addr_w-1:0]   pop_addr,
  output logic [mem_addr_pkg::data_w-1:0]   pop_data,
  output logic                              empty,
  output logic                              full,
  output logic [mem_addr_pkg::level_w-1:0]  level
);

  localparam int entry_w = mem_addr_pkg::addr_w + mem_addr_pkg::data_w;  // 36 bits

  logic [entry_w-1:0] mem [mem_addr_pkg::fifo_depth];  // Address in upper bits

  logic [mem_addr_pkg::ptr_w-1:0]   wr_ptr;
  logic [mem_addr_pkg::ptr_w-1:0]   rd_ptr;
  logic [mem_addr_pkg::level_w-1:0] count;

  // Head entry, valid whenever not empty
  assign {pop_addr, pop_data} = mem[rd_ptr];

  assign level = count;
  assign empty = (count == '0);
  assign full  = (count == mem_addr_pkg::level_w'(mem_addr_pkg::fifo_depth));

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {push_addr, push_data};
    end
  end

  // Pointers wrap naturally at fifo_depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither, level holds
      endcase
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the DRAM address path testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_mem_addr -o sim_mem_addr > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_mem_addr > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" sim.log; then
  exit 0
fi
exit 1

//--- tb_mem_addr.sv
/*
 * Testbench for the DRAM address path
 * Replays the vector file over APB, runs power-down requests alone
 * and ends with a burst that fills the request FIFO
 */
module tb_mem_addr;

  localparam int max_vec = 64;

  logic                              clk;
  logic                              reset;
  logic                              psel;
  logic                              penable;
  logic                              pwrite;
  logic [mem_addr_pkg::paddr_w-1:0]  paddr;
  logic [mem_addr_pkg::pdata_w-1:0]  pwdata;
  logic [mem_addr_pkg::pdata_w-1:0]  prdata;
  logic                              pready;
  logic                              pslverr;
  logic                              pd4;
  logic [mem_addr_pkg::half_w-1:0]   aa;
  logic                              ras_n;
  logic                              cas_n;
  logic                              we_n;
  logic [mem_addr_pkg::data_w-1:0]   dq_out;
  logic                              final_rd;  // Tells the checker the closing read is on

  // Vector table read by the checker through hierarchical names
  logic [mem_addr_pkg::addr_w-1:0] vec_addr [max_vec];
  logic [mem_addr_pkg::data_w-1:0] vec_data [max_vec];
  logic                            vec_pd   [max_vec];
  int                              n_vec = 0;
  int                              cycles = 0;
  int                              limit = 1000;  // Replaced once the vector count is known
  logic [31:0]                     lcg_state = 32'd22613;
  logic [31:0]                     rd_word;

  mem_addr_top u_dut (.*);
  mem_addr_checker u_chk (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: DRAM cycles did not finish");
      $display("%0d errors, %0d of %0d requests retired", u_chk.errors, u_chk.idx, n_vec);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // One APB transfer entered and left 1 unit after a rising edge
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1 penable = 1'b1;
    do @(negedge clk); while (!pready);  // Wait states while the FIFO is full
    rdata = prdata;
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  // Poll status until busy and level both read zero
  task automatic wait_idle();
    logic [31:0] st;
    st = 32'hF;
    while (st[3:0] != 4'h0) apb_xfer(1'b0, mem_addr_pkg::reg_status_off, 32'h0, st);
  endtask

  task automatic load_vectors();
    int                              fd;
    int                              r;
    string                           line;
    logic [mem_addr_pkg::addr_w-1:0] a;
    logic [mem_addr_pkg::data_w-1:0] d;
    logic                            p;
    fd = $fopen("mem_addr_vectors.txt", "r");
    if (fd == 0) $display("cannot open mem_addr_vectors.txt");
    while (fd != 0 && !$feof(fd) && n_vec < max_vec - 1) begin
      line = "";
      r = $fgets(line, fd);
      if (line.len() > 0 && line.getc(0) != 8'h23) begin  // Skip comment lines
        r = $sscanf(line, "%h %h %h", a, d, p);
        if (r == 3) begin
          vec_addr[6'(n_vec)] = a;
          vec_data[6'(n_vec)] = d;
          vec_pd[6'(n_vec)]   = p;
          n_vec++;
        end
      end
    end
    if (fd != 0) $fclose(fd);
  endtask

  task automatic run_vectors();
    logic [5:0]                      vi;
    logic [mem_addr_pkg::addr_w-1:0] cur_addr;
    logic                            have_addr;
    have_addr = 1'b0;
    for (vi = '0; int'(vi) < n_vec; vi++) begin
      if (vec_pd[vi]) begin
        wait_idle();  // Power-down request runs on its own
        pd4 = 1'b1;
      end
      if (!have_addr || vec_addr[vi] != cur_addr) begin
        lcg_state = lcg_next(lcg_state);
        idle_cycles(int'(lcg_state[17:16]));  // Gap of 0 to 3 cycles
        apb_xfer(1'b1, mem_addr_pkg::reg_addr_off, {12'h0, vec_addr[vi]}, rd_word);
        cur_addr  = vec_addr[vi];
        have_addr = 1'b1;
      end
      apb_xfer(1'b1, mem_addr_pkg::reg_data_off, {16'h0, vec_data[vi]}, rd_word);
      if (vec_pd[vi]) begin
        wait_idle();
        pd4 = 1'b0;
      end
    end
  endtask

  initial begin
    reset    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    pd4      = 1'b0;
    final_rd = 1'b0;
    load_vectors();
    limit = n_vec * 12 + 200;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    run_vectors();
    wait_idle();
    apb_xfer(1'b1, 4'hC, 32'hFFFF_FFFF, rd_word);  // Unmapped offset
    apb_xfer(1'b0, mem_addr_pkg::reg_addr_off, 32'h0, rd_word);
    final_rd = 1'b1;
    apb_xfer(1'b0, mem_addr_pkg::reg_status_off, 32'h0, rd_word);
    final_rd = 1'b0;
    if (n_vec == 0) $display("no vectors were read from mem_addr_vectors.txt");
    if (!u_chk.final_seen) $display("closing status read never reached the checker");
    $display("%0d errors, %0d of %0d requests retired", u_chk.errors, u_chk.idx, n_vec);
    if (u_chk.errors == 0 && u_chk.final_seen && n_vec > 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
